// File: src/sdadc_pkg.sv
package sdadc_pkg;

    // Decimation
    localparam int DEC_LEN   = 1024;                // Clocks per window
    localparam int WIN_CNT_W = $clog2(DEC_LEN);
    localparam int SAMPLE_W  = 11;                  // Counts 0 to DEC_LEN

    // Dump line format
    localparam int HEX_DIGITS = 3;
    localparam int HEX_W      = 4 * HEX_DIGITS;     // Sample padded to whole nibbles
    localparam int LINE_LEN   = 9;                  // Two samples, space, CR, LF
    localparam int LINE_IDX_W = $clog2(LINE_LEN);

    localparam logic [7:0] CHAR_SPACE = 8'h20;
    localparam logic [7:0] CHAR_CR    = 8'h0D;
    localparam logic [7:0] CHAR_LF    = 8'h0A;

    // UART 8N1
    localparam int CLK_PER_BIT  = 8;
    localparam int BIT_TIME_W   = $clog2(CLK_PER_BIT);
    localparam int UART_FRAME_W = 10;               // Start, 8 data, stop
    localparam int FRAME_CNT_W  = $clog2(UART_FRAME_W);

    // Trim PWM and its SPI register
    localparam int PWM_W      = 8;
    localparam int DUTY_BIT_W = $clog2(PWM_W);

    localparam int SYNC_STAGES = 2;                 // Flops on async pins

endpackage

// File: src/sd_channel.sv
`timescale 1ns/10ps

module sd_channel (
    input  logic                          clk,
    input  logic                          i_rst,
    input  logic                          i_comp,
    output logic                          o_fb,
    output logic [sdadc_pkg::SAMPLE_W-1:0] o_sample,
    output logic                          o_sample_stb
);
    import sdadc_pkg::*;

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   bit_s;
    logic [WIN_CNT_W-1:0]   win_cnt;
    logic [SAMPLE_W-1:0]    ones_acc;
    logic                   win_end;

    assign bit_s   = sync_q[SYNC_STAGES-1];
    assign o_fb    = bit_s;                         // Drives the RC network
    assign win_end = (win_cnt == WIN_CNT_W'(DEC_LEN - 1));

    always_ff @(posedge clk) begin
        if (i_rst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], i_comp};
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            win_cnt      <= '0;
            ones_acc     <= '0;
            o_sample_stb <= 1'b0;
        end else begin
            o_sample_stb <= win_end;
            if (win_end) begin
                win_cnt  <= '0;
                ones_acc <= '0;                     // Restart for next window
            end else begin
                win_cnt  <= win_cnt + 1'b1;
                ones_acc <= ones_acc + SAMPLE_W'(bit_s);
            end
        end
    end

    // Last bit of the window is folded in here
    always_ff @(posedge clk) begin
        if (win_end) begin
            o_sample <= ones_acc + SAMPLE_W'(bit_s);
        end
    end

endmodule

// File: src/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic       clk,
    input  logic       i_rst,
    input  logic [7:0] i_data,
    input  logic       i_stb,
    output logic       o_tx,
    output logic       o_busy
);
    import sdadc_pkg::*;

    logic [UART_FRAME_W-1:0] frame;
    logic [BIT_TIME_W-1:0]   tick_cnt;
    logic [FRAME_CNT_W-1:0]  bit_cnt;
    logic                    bit_done;

    assign bit_done = (tick_cnt == BIT_TIME_W'(CLK_PER_BIT - 1));
    assign o_tx     = frame[0];                     // Idle high once shifted out

    always_ff @(posedge clk) begin
        if (i_rst) begin
            frame    <= '1;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_busy   <= 1'b0;
        end else if (!o_busy) begin
            if (i_stb) begin
                frame    <= {1'b1, i_data, 1'b0};   // Stop, data, start
                tick_cnt <= '0;
                bit_cnt  <= '0;
                o_busy   <= 1'b1;
            end
        end else if (bit_done) begin
            tick_cnt <= '0;
            frame    <= {1'b1, frame[UART_FRAME_W-1:1]};
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == FRAME_CNT_W'(UART_FRAME_W - 1)) begin
                o_busy <= 1'b0;                     // Stop bit complete
            end
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

endmodule

// File: src/hex_dump.sv
`timescale 1ns/10ps

module hex_dump (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic [sdadc_pkg::SAMPLE_W-1:0] i_sample0,
    input  logic [sdadc_pkg::SAMPLE_W-1:0] i_sample1,
    input  logic                           i_sample_stb,
    output logic                           o_tx
);
    import sdadc_pkg::*;

    logic [SAMPLE_W-1:0]   s0;
    logic [SAMPLE_W-1:0]   s1;
    logic [LINE_IDX_W-1:0] idx;
    logic                  active;
    logic [7:0]            tx_data;
    logic                  tx_stb;
    logic                  tx_busy;
    logic                  start;
    logic                  send;

    // ASCII byte at position idx of the line for samples a and b
    function automatic logic [7:0] line_char(
        input logic [LINE_IDX_W-1:0] pos_in,
        input logic [SAMPLE_W-1:0]   a,
        input logic [SAMPLE_W-1:0]   b
    );
        logic [HEX_W-1:0] word;
        logic [3:0]       nib;
        logic [7:0]       ch;
        int               pos;
        int               i;

        i    = int'(pos_in);
        word = '0;
        pos  = 0;
        if (i < HEX_DIGITS) begin
            word = HEX_W'(a);
            pos  = i;
        end else if (i > HEX_DIGITS && i < LINE_LEN - 2) begin
            word = HEX_W'(b);
            pos  = i - HEX_DIGITS - 1;
        end
        nib = word[4 * (HEX_DIGITS - 1 - pos) +: 4];   // Most significant first
        if (i == HEX_DIGITS) begin
            ch = CHAR_SPACE;
        end else if (i == LINE_LEN - 2) begin
            ch = CHAR_CR;
        end else if (i == LINE_LEN - 1) begin
            ch = CHAR_LF;
        end else if (nib < 4'd10) begin
            ch = 8'h30 + 8'(nib);
        end else begin
            ch = 8'h37 + 8'(nib);                   // Upper-case A-F
        end
        return ch;
    endfunction

    // Pairs arriving mid-line are dropped
    assign start = !active && i_sample_stb && !tx_busy && !tx_stb;
    assign send  = active && !tx_busy && !tx_stb;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            active <= 1'b0;
            idx    <= '0;
            tx_stb <= 1'b0;
        end else begin
            tx_stb <= start || send;
            if (start) begin
                active <= 1'b1;
                idx    <= LINE_IDX_W'(1);           // Byte 0 goes out now
            end else if (send) begin
                if (idx == LINE_IDX_W'(LINE_LEN - 1)) begin
                    active <= 1'b0;
                    idx    <= '0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            s0      <= i_sample0;
            s1      <= i_sample1;
            tx_data <= line_char('0, i_sample0, i_sample1);
        end else if (send) begin
            tx_data <= line_char(idx, s0, s1);
        end
    end

    uart_tx u_tx (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_data (tx_data),
        .i_stb  (tx_stb),
        .o_tx   (o_tx),
        .o_busy (tx_busy)
    );

endmodule

// File: src/spi_cfg.sv
`timescale 1ns/10ps

module spi_cfg (
    input  logic                        clk,
    input  logic                        i_rst,
    input  logic                        i_spi_sck,
    input  logic                        i_spi_mosi,
    input  logic                        i_spi_cs_n,
    output logic                        o_spi_miso,
    output logic [sdadc_pkg::PWM_W-1:0] o_duty
);
    import sdadc_pkg::*;

    logic [SYNC_STAGES-1:0] sck_q;
    logic [SYNC_STAGES-1:0] mosi_q;
    logic [SYNC_STAGES-1:0] cs_n_q;
    logic                   sck_d;
    logic                   sck_rise;
    logic                   mosi_s;
    logic                   cs_n_s;
    logic [DUTY_BIT_W-1:0]  bit_cnt;
    logic [PWM_W-2:0]       shift;

    assign mosi_s     = mosi_q[SYNC_STAGES-1];
    assign cs_n_s     = cs_n_q[SYNC_STAGES-1];
    assign sck_rise   = sck_q[SYNC_STAGES-1] && !sck_d;
    assign o_spi_miso = 1'b1;                       // No reply path

    always_ff @(posedge clk) begin
        if (i_rst) begin
            sck_q  <= '0;
            mosi_q <= '0;
            cs_n_q <= '1;                           // Deselected
            sck_d  <= 1'b0;
        end else begin
            sck_q  <= {sck_q[SYNC_STAGES-2:0], i_spi_sck};
            mosi_q <= {mosi_q[SYNC_STAGES-2:0], i_spi_mosi};
            cs_n_q <= {cs_n_q[SYNC_STAGES-2:0], i_spi_cs_n};
            sck_d  <= sck_q[SYNC_STAGES-1];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            bit_cnt <= '0;
            o_duty  <= '0;
        end else if (cs_n_s) begin
            bit_cnt <= '0;                          // Partial byte discarded
        end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == DUTY_BIT_W'(PWM_W - 1)) begin
                o_duty <= {shift, mosi_s};
            end
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (sck_rise) begin
            shift <= {shift[PWM_W-3:0], mosi_s};
        end
    end

endmodule

// File: src/pwm_trim.sv
`timescale 1ns/10ps

module pwm_trim (
    input  logic                        clk,
    input  logic                        i_rst,
    input  logic [sdadc_pkg::PWM_W-1:0] i_duty,
    output logic                        o_pwm
);
    import sdadc_pkg::*;

    logic [PWM_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            cnt   <= '0;
            o_pwm <= 1'b0;
        end else begin
            cnt   <= cnt + 1'b1;                    // Wraps every 2**PWM_W clocks
            o_pwm <= (cnt < i_duty);
        end
    end

endmodule

// File: src/sdadc_top.sv
`timescale 1ns/10ps

module sdadc_top (
    input  logic clk,
    input  logic i_rst,
    input  logic i_comp0,
    input  logic i_comp1,
    input  logic i_spi_sck,
    input  logic i_spi_mosi,
    input  logic i_spi_cs_n,
    output logic o_fb0,
    output logic o_fb1,
    output logic o_tx,
    output logic o_pwm,
    output logic o_spi_miso
);
    import sdadc_pkg::*;

    logic [SAMPLE_W-1:0] sample0;
    logic [SAMPLE_W-1:0] sample1;
    logic                sample_stb;
    logic [PWM_W-1:0]    duty;

    sd_channel u_ch0 (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_comp       (i_comp0),
        .o_fb         (o_fb0),
        .o_sample     (sample0),
        .o_sample_stb (sample_stb)
    );

    // Strobe left open since it coincides with channel 0's
    sd_channel u_ch1 (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_comp       (i_comp1),
        .o_fb         (o_fb1),
        .o_sample     (sample1),
        .o_sample_stb ()
    );

    hex_dump u_dump (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_sample0    (sample0),
        .i_sample1    (sample1),
        .i_sample_stb (sample_stb),
        .o_tx         (o_tx)
    );

    spi_cfg u_spi (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_spi_sck  (i_spi_sck),
        .i_spi_mosi (i_spi_mosi),
        .i_spi_cs_n (i_spi_cs_n),
        .o_spi_miso (o_spi_miso),
        .o_duty     (duty)
    );

    pwm_trim u_pwm (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_duty (duty),
        .o_pwm  (o_pwm)
    );

endmodule

// File: testbench/tb_sdadc.sv
`timescale 1ns/10ps

module tb_sdadc;

    localparam int CLK_NS     = 40;
    localparam int RST_CYCLES = 10;
    localparam int WIN        = 1024;               // Clocks per decimation window
    localparam int SYNC_DLY   = 2;                  // Synchronizer depth
    localparam int BIT_CLKS   = 8;                  // UART bit time
    localparam int LINE_BYTES = 9;
    localparam int N_WIN      = 8;
    localparam int TOTAL_BITS = N_WIN * WIN;
    localparam int SCK_HALF   = 8;                  // Slow SPI clock
    localparam int PWM_PERIOD = 256;
    localparam int LOAD_CLKS  = SYNC_DLY + 2;
    localparam int N_SPI      = 4;
    localparam int SPI_CLKS   = 6 * WIN;
    localparam int WDOG_NS    = ((N_WIN + 2) * WIN + SPI_CLKS) * CLK_NS;
    localparam logic [31:0] SEED = 32'h5006;

    logic clk;
    logic i_rst;
    logic i_comp0;
    logic i_comp1;
    logic i_spi_sck;
    logic i_spi_mosi;
    logic i_spi_cs_n;
    logic o_fb0;
    logic o_fb1;
    logic o_tx;
    logic o_pwm;
    logic o_spi_miso;

    bit         hist0 [TOTAL_BITS];
    bit         hist1 [TOTAL_BITS];
    logic [7:0] rx_q [$];
    bit         lines_done = 1'b0;
    int         cur_line_test = 4;
    int         check_cnt = 0;
    int         err_cnt = 0;
    int         test_checks [1:6];
    int         test_err [1:6];

    sdadc_top DUT (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_comp0    (i_comp0),
        .i_comp1    (i_comp1),
        .i_spi_sck  (i_spi_sck),
        .i_spi_mosi (i_spi_mosi),
        .i_spi_cs_n (i_spi_cs_n),
        .o_fb0      (o_fb0),
        .o_fb1      (o_fb1),
        .o_tx       (o_tx),
        .o_pwm      (o_pwm),
        .o_spi_miso (o_spi_miso)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    // Window k sums bits k*WIN-2 through k*WIN+WIN-3 and treats earlier bits as zero
    function automatic int window_count(input int ch, input int k);
        int n;
        int ones;
        ones = 0;
        for (n = k * WIN - SYNC_DLY; n < (k + 1) * WIN - SYNC_DLY; n++) begin
            if (n >= 0) begin
                ones += (ch == 0) ? int'(hist0[n]) : int'(hist1[n]);
            end
        end
        return ones;
    endfunction

    function automatic logic [7:0] hex_ascii(input int nib);
        if (nib < 10) begin
            return 8'(48 + nib);
        end
        return 8'(55 + nib);                        // Upper case
    endfunction

    // "AAA BBB" then CR LF
    function automatic logic [7:0] line_byte(input int a, input int b, input int pos);
        if (pos < 3) begin
            return hex_ascii((a >> (4 * (2 - pos))) & 15);
        end
        if (pos == 3) begin
            return 8'h20;
        end
        if (pos < 7) begin
            return hex_ascii((b >> (4 * (6 - pos))) & 15);
        end
        return (pos == 7) ? 8'h0D : 8'h0A;
    endfunction

    function automatic int pwm_high_count(input int duty);
        int c;
        int highs;
        highs = 0;
        for (c = 0; c < PWM_PERIOD; c++) begin
            if (c < duty) begin
                highs++;
            end
        end
        return highs;
    endfunction

    task automatic record_check(input int test, input bit ok);
        check_cnt++;
        test_checks[test]++;
        if (!ok) begin
            err_cnt++;
            test_err[test]++;
        end
    endtask

    task automatic report_test(input int test, input string name);
        if (test_err[test] == 0) begin
            $display("Test %0d %s: ok, %0d checks", test, name, test_checks[test]);
        end else begin
            $display("Test %0d %s: %0d of %0d checks failed", test, name,
                     test_err[test], test_checks[test]);
        end
    endtask

    task automatic check_idle(input string when);
        if (o_tx !== 1'b1) begin
            $display("MISMATCH o_tx %s: got %h expected 1", when, o_tx);
        end
        record_check(1, o_tx === 1'b1);
        if (o_spi_miso !== 1'b1) begin
            $display("MISMATCH o_spi_miso %s: got %h expected 1", when, o_spi_miso);
        end
        record_check(1, o_spi_miso === 1'b1);
        if (o_pwm !== 1'b0) begin
            $display("MISMATCH o_pwm %s: got %h expected 0", when, o_pwm);
        end
        record_check(1, o_pwm === 1'b0);
        if (o_fb0 !== 1'b0 || o_fb1 !== 1'b0) begin
            $display("MISMATCH o_fb0/o_fb1 %s: got %h/%h expected 0/0", when, o_fb0, o_fb1);
        end
        record_check(1, o_fb0 === 1'b0 && o_fb1 === 1'b0);
    endtask

    // Window 1 is ch0 high, window 2 ch1 high, the rest random density
    task automatic drive_windows();
        int n;
        int w;
        int p0;
        int p1;
        bit exp0;
        bit exp1;
        p0 = 0;
        p1 = 0;
        for (n = 0; n < TOTAL_BITS - SYNC_DLY; n++) begin
            exp0 = (n >= SYNC_DLY) ? hist0[n - SYNC_DLY] : 1'b0;
            exp1 = (n >= SYNC_DLY) ? hist1[n - SYNC_DLY] : 1'b0;
            if (o_fb0 !== exp0) begin
                $display("MISMATCH o_fb0 at bit %0d: got %h expected %h", n, o_fb0, exp0);
            end
            record_check(2, o_fb0 === exp0);
            if (o_fb1 !== exp1) begin
                $display("MISMATCH o_fb1 at bit %0d: got %h expected %h", n, o_fb1, exp1);
            end
            record_check(2, o_fb1 === exp1);
            if (n == 1) begin
                check_idle("after reset");
                report_test(1, "reset state");
            end
            if (n == 0 || (n + SYNC_DLY) % WIN == 0) begin
                w = (n + SYNC_DLY) / WIN;
                if (w == 1) begin
                    p0 = 256;
                    p1 = 0;
                end else if (w == 2) begin
                    p0 = 0;
                    p1 = 256;
                end else begin
                    p0 = int'($urandom % 257);      // Ones per 256
                    p1 = int'($urandom % 257);
                end
            end
            hist0[n] = (int'($urandom % 256) < p0);
            hist1[n] = (int'($urandom % 256) < p1);
            i_comp0  = hist0[n];
            i_comp1  = hist1[n];
            @(negedge clk);
        end
        i_comp0 = 1'b0;
        i_comp1 = 1'b0;
    endtask

    // Mode 0, MSB first
    task automatic spi_send(input logic [7:0] data, input int nbits);
        int i;
        i_spi_cs_n = 1'b0;
        repeat (SCK_HALF) @(negedge clk);
        for (i = 0; i < nbits; i++) begin
            i_spi_mosi = data[7 - i];
            repeat (SCK_HALF) @(negedge clk);
            i_spi_sck = 1'b1;
            repeat (SCK_HALF) @(negedge clk);
            i_spi_sck = 1'b0;
        end
        repeat (SCK_HALF) @(negedge clk);
        i_spi_cs_n = 1'b1;
        i_spi_mosi = 1'b0;
        repeat (SCK_HALF) @(negedge clk);
    endtask

    task automatic check_pwm(input int test, input logic [7:0] duty);
        int i;
        int highs;
        int exp_highs;
        highs = 0;
        repeat (LOAD_CLKS + PWM_PERIOD) @(negedge clk);
        for (i = 0; i < PWM_PERIOD; i++) begin
            if (o_pwm === 1'b1) begin
                highs++;
            end
            @(negedge clk);
        end
        exp_highs = pwm_high_count(int'(duty));
        if (highs != exp_highs) begin
            $display("MISMATCH o_pwm high count for duty %h: got %h expected %h",
                     duty, highs, exp_highs);
        end
        record_check(test, highs == exp_highs);
    endtask

    initial begin : uart_decoder
        logic [7:0] data;
        int         i;
        forever begin
            @(negedge clk);
            if (!i_rst && o_tx === 1'b0) begin
                repeat (BIT_CLKS / 2) @(negedge clk);   // Mid start bit
                for (i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(negedge clk);
                    data[i] = o_tx;
                end
                repeat (BIT_CLKS) @(negedge clk);
                if (!lines_done) begin
                    if (o_tx !== 1'b1) begin
                        $display("Framing error on o_tx: stop bit missing after byte %h",
                                 data);
                    end
                    record_check(cur_line_test, o_tx === 1'b1);
                end
                rx_q.push_back(data);
            end
        end
    end

    initial begin : line_checker
        int         k;
        int         pos;
        int         c0;
        int         c1;
        logic [7:0] got;
        logic [7:0] exp_b;
        c0 = 0;
        c1 = 0;
        for (k = 0; k < N_WIN; k++) begin
            cur_line_test = (k == 1 || k == 2) ? 3 : 4;
            for (pos = 0; pos < LINE_BYTES; pos++) begin
                while (rx_q.size() == 0) begin
                    @(negedge clk);
                end
                got = rx_q.pop_front();
                if (pos == 0) begin
                    if (k == 1) begin
                        c0 = 1024;                  // "400 000"
                        c1 = 0;
                    end else if (k == 2) begin
                        c0 = 0;
                        c1 = 1024;
                    end else begin
                        c0 = window_count(0, k);
                        c1 = window_count(1, k);
                    end
                end
                exp_b = line_byte(c0, c1, pos);
                if (got !== exp_b) begin
                    $display("MISMATCH o_tx line %0d byte %0d: got %h expected %h",
                             k, pos, got, exp_b);
                end
                record_check(cur_line_test, got === exp_b);
            end
        end
        lines_done = 1'b1;
    end

    initial begin : main
        int         i;
        int         j;
        logic [7:0] spi_byte;
        logic [7:0] duty_now;
        i_rst      = 1'b1;
        i_comp0    = 1'b0;
        i_comp1    = 1'b0;
        i_spi_sck  = 1'b0;
        i_spi_mosi = 1'b0;
        i_spi_cs_n = 1'b1;
        void'($urandom(SEED));
        for (i = 0; i < RST_CYCLES; i++) begin
            @(negedge clk);
            check_idle("in reset");
        end
        i_rst = 1'b0;
        drive_windows();
        report_test(2, "feedback path");
        while (!lines_done) begin
            @(negedge clk);
        end
        report_test(3, "constant levels");
        report_test(4, "random density windows");

        duty_now = 8'h00;
        for (j = 0; j < N_SPI; j++) begin
            spi_byte = 8'($urandom);
            spi_send(spi_byte, 8);
            check_pwm(5, spi_byte);
            duty_now = spi_byte;
        end
        report_test(5, "SPI duty load");

        spi_send(8'($urandom), 5);                  // CS rises mid-byte
        check_pwm(6, duty_now);
        spi_byte = 8'($urandom);
        spi_send(spi_byte, 8);
        check_pwm(6, spi_byte);
        report_test(6, "aborted SPI byte");

        $display("Summary: %0d checks passed, %0d errors", check_cnt - err_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: filelist.f
src/sdadc_pkg.sv
src/sd_channel.sv
src/uart_tx.sv
src/hex_dump.sv
src/spi_cfg.sv
src/pwm_trim.sv
src/sdadc_top.sv
testbench/tb_sdadc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sdadc
RTL_TOP   ?= sdadc_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= Testbench passed
RTL_SRCS  ?= src/sdadc_pkg.sv src/sd_channel.sv src/uart_tx.sv src/hex_dump.sv \
             src/spi_cfg.sv src/pwm_trim.sv src/sdadc_top.sv
TB_SRCS   ?= testbench/tb_sdadc.sv
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
